//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_dec_id_stage
RTL_TOP    := dec_id_stage
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing
PASS_MSG   := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- dec_ctrl_pkg.sv
/*
 Decoded control encodings passed from decode to execute.
 Encodings are internal to the core and not tied to the ISA bits,
 except md_op_e which follows funct3 of the M instructions.
*/
`default_nettype none

package dec_ctrl_pkg;

  // ALU operation
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B     // Operand b straight through, for LUI
  } alu_op_e;

  // Multiply/divide operation, same order as funct3
  typedef enum logic [2:0] {
    MUL,
    MULH,
    MULHSU,
    MULHU,
    DIV,
    DIVU,
    REM,
    REMU
  } md_op_e;

  // Control transfer kind
  typedef enum logic [1:0] {
    BR_NONE,
    BR_JAL,
    BR_JALR,
    BR_COND
  } branch_e;

  // System operation
  typedef enum logic [2:0] {
    SYS_NONE,
    SYS_ECALL,
    SYS_EBREAK,
    SYS_MRET,
    SYS_WFI,
    SYS_FENCEI
  } sys_op_e;

  // Memory access size
  typedef enum logic [1:0] {
    LSU_BYTE,
    LSU_HALF,
    LSU_WORD
  } lsu_size_e;

endpackage

`default_nettype wire

//--- dec_decoder.sv
/*
 Combined decoder. The M result wins over the I result.
 A word neither decoder matches is illegal with all enables low.
 fault_i suppresses every enable, rf_we, branch, sys_op and illegal,
 so a fetch fault is reported on its own.
*/
`timescale 1ns/100ps
`include "dec_settings.svh"
`default_nettype none

module dec_decoder import dec_ctrl_pkg::*; (
  input  logic [31:0] instr_i,
  input  logic        fault_i,        // Fetch fault on this word
  output logic        alu_en_o,
  output alu_op_e     alu_op_o,
  output logic        op_b_imm_o,
  output logic        md_en_o,
  output md_op_e      md_op_o,
  output logic        rf_we_o,
  output logic [1:0]  rf_re_o,
  output logic        lsu_en_o,
  output logic        lsu_we_o,
  output lsu_size_e   lsu_size_o,
  output logic        lsu_sign_ext_o,
  output branch_e     branch_o,
  output sys_op_e     sys_op_o,
  output logic        illegal_o
);

  // I decoder results
  logic       i_match, i_alu_en, i_op_b_imm, i_rf_we, i_lsu_en, i_lsu_we, i_sign_ext;
  logic [1:0] i_rf_re;
  alu_op_e    i_alu_op;
  lsu_size_e  i_lsu_size;
  branch_e    i_branch;
  sys_op_e    i_sys_op;

  // M decoder results
  logic       m_match, m_rf_we;
  logic [1:0] m_rf_re;
  md_op_e     m_md_op;

  // Muxed, before fault suppression
  logic    alu_en, md_en, rf_we, lsu_en, lsu_we, illegal;
  branch_e branch;
  sys_op_e sys_op;

  dec_i_decoder i_decoder_inst (
    .instr_i        (instr_i),
    .match_o        (i_match),
    .alu_en_o       (i_alu_en),
    .alu_op_o       (i_alu_op),
    .op_b_imm_o     (i_op_b_imm),
    .rf_we_o        (i_rf_we),
    .rf_re_o        (i_rf_re),
    .lsu_en_o       (i_lsu_en),
    .lsu_we_o       (i_lsu_we),
    .lsu_size_o     (i_lsu_size),
    .lsu_sign_ext_o (i_sign_ext),
    .branch_o       (i_branch),
    .sys_op_o       (i_sys_op)
  );

  generate
    if (`DEC_M_EXT != 0) begin : gen_m_dec
      dec_m_decoder m_decoder_inst (
        .instr_i (instr_i),
        .match_o (m_match),
        .md_op_o (m_md_op),
        .rf_we_o (m_rf_we),
        .rf_re_o (m_rf_re)
      );
    end else begin : gen_no_m_dec
      assign m_match = 1'b0;                    // M encodings fall through to illegal
      assign m_md_op = MUL;
      assign m_rf_we = 1'b0;
      assign m_rf_re = 2'b00;
    end
  endgenerate

  //////////////////////////////////////////////////
  // Sub-decoder select
  //////////////////////////////////////////////////
  always_comb begin
    alu_en   = i_match & ~m_match & i_alu_en;
    md_en    = m_match;
    lsu_en   = i_match & ~m_match & i_lsu_en;
    lsu_we   = i_match & ~m_match & i_lsu_we;
    branch   = (i_match && !m_match) ? i_branch : BR_NONE;
    sys_op   = (i_match && !m_match) ? i_sys_op : SYS_NONE;
    illegal  = !i_match && !m_match;
    rf_we    = m_match ? m_rf_we : (i_match & i_rf_we);
    rf_re_o  = m_match ? m_rf_re : (i_match ? i_rf_re : 2'b00);
  end

  // Payload fields, only meaningful with their enable
  assign alu_op_o       = i_alu_op;
  assign op_b_imm_o     = i_op_b_imm;
  assign md_op_o        = m_md_op;
  assign lsu_size_o     = i_lsu_size;
  assign lsu_sign_ext_o = i_sign_ext;

  //////////////////////////////////////////////////
  // Fault suppression
  //////////////////////////////////////////////////
  assign alu_en_o  = fault_i ? 1'b0     : alu_en;
  assign md_en_o   = fault_i ? 1'b0     : md_en;
  assign rf_we_o   = fault_i ? 1'b0     : rf_we;
  assign lsu_en_o  = fault_i ? 1'b0     : lsu_en;
  assign lsu_we_o  = fault_i ? 1'b0     : lsu_we;
  assign branch_o  = fault_i ? BR_NONE  : branch;
  assign sys_op_o  = fault_i ? SYS_NONE : sys_op;
  assign illegal_o = fault_i ? 1'b0     : illegal;  // Fault reported instead

  // I decoder must leave all MULDIV words to the M decoder
  always_comb begin
    assert (!(i_match && m_match)) else $error("I and M decoders both matched");
  end

endmodule

`default_nettype wire

//--- dec_i_decoder.sv
/*
 RV32I base decoder, purely combinational.
 CSR instructions are not decoded and come out unmatched.
 OP words with the MUL/DIV funct7 are left unmatched for the M decoder.
*/
`timescale 1ns/100ps
`default_nettype none

module dec_i_decoder import dec_isa_pkg::*; import dec_ctrl_pkg::*; (
  input  logic [31:0] instr_i,
  output logic        match_o,         // Word is a valid RV32I instruction
  output logic        alu_en_o,
  output alu_op_e     alu_op_o,
  output logic        op_b_imm_o,      // Operand b from the immediate
  output logic        rf_we_o,
  output logic [1:0]  rf_re_o,         // [0] rs1, [1] rs2
  output logic        lsu_en_o,
  output logic        lsu_we_o,
  output lsu_size_e   lsu_size_o,
  output logic        lsu_sign_ext_o,
  output branch_e     branch_o,
  output sys_op_e     sys_op_o
);

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] funct12;

  assign opcode  = opcode_e'(instr_i[6:0]);
  assign funct3  = instr_i[14:12];
  assign funct7  = instr_i[31:25];
  assign funct12 = instr_i[31:20];

  // Shared funct3 map of OP and OP_IMM, funct7 handled by the caller
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3);
    case (f3)
      3'b000:  return ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  always_comb begin
    match_o        = 1'b1;
    alu_en_o       = 1'b0;
    alu_op_o       = ADD;
    op_b_imm_o     = 1'b0;
    rf_we_o        = 1'b0;
    rf_re_o        = 2'b00;
    lsu_en_o       = 1'b0;
    lsu_we_o       = 1'b0;
    lsu_size_o     = LSU_WORD;
    lsu_sign_ext_o = 1'b0;
    branch_o       = BR_NONE;
    sys_op_o       = SYS_NONE;

    case (opcode)
      LUI, AUIPC: begin
        alu_en_o   = 1'b1;
        alu_op_o   = (opcode == LUI) ? PASS_B : ADD;  // AUIPC adds to the PC
        op_b_imm_o = 1'b1;
        rf_we_o    = 1'b1;
      end
      JAL, JALR: begin
        alu_en_o   = 1'b1;                             // ALU forms the link address
        op_b_imm_o = 1'b1;
        rf_we_o    = 1'b1;
        branch_o   = (opcode == JAL) ? BR_JAL : BR_JALR;
        rf_re_o    = (opcode == JALR) ? 2'b01 : 2'b00;
        if (opcode == JALR && funct3 != 3'b000) match_o = 1'b0;
      end
      BRANCH: begin
        alu_en_o = 1'b1;
        rf_re_o  = 2'b11;
        branch_o = BR_COND;
        case (funct3)
          3'b000, 3'b001: alu_op_o = SUB;   // BEQ, BNE
          3'b100, 3'b101: alu_op_o = SLT;   // BLT, BGE
          3'b110, 3'b111: alu_op_o = SLTU;  // BLTU, BGEU
          default:        match_o  = 1'b0;
        endcase
      end
      LOAD: begin
        lsu_en_o       = 1'b1;
        rf_we_o        = 1'b1;
        rf_re_o        = 2'b01;
        lsu_size_o     = lsu_size_e'(funct3[1:0]);
        lsu_sign_ext_o = !funct3[2];          // LBU, LHU zero extend
        if (funct3[1:0] == 2'b11 || funct3 == 3'b110) match_o = 1'b0;
      end
      STORE: begin
        lsu_en_o   = 1'b1;
        lsu_we_o   = 1'b1;
        rf_re_o    = 2'b11;
        lsu_size_o = lsu_size_e'(funct3[1:0]);
        if (funct3[2] || funct3[1:0] == 2'b11) match_o = 1'b0;
      end
      OP_IMM: begin
        alu_en_o   = 1'b1;
        op_b_imm_o = 1'b1;
        rf_we_o    = 1'b1;
        rf_re_o    = 2'b01;
        alu_op_o   = alu_from_funct3(funct3);
        // Shift amounts carry funct7 in the immediate
        if (funct3 == 3'b001 && funct7 != 7'h00) match_o = 1'b0;
        if (funct3 == 3'b101) begin
          if (funct7 == 7'h20) alu_op_o = SRA;
          else if (funct7 != 7'h00) match_o = 1'b0;
        end
      end
      OP: begin
        alu_en_o = 1'b1;
        rf_we_o  = 1'b1;
        rf_re_o  = 2'b11;
        alu_op_o = alu_from_funct3(funct3);
        if (funct7 == 7'h20 && funct3 == 3'b000) alu_op_o = SUB;
        else if (funct7 == 7'h20 && funct3 == 3'b101) alu_op_o = SRA;
        else if (funct7 != 7'h00) match_o = 1'b0;      // Also FUNCT7_MULDIV
      end
      MISC_MEM: begin
        case (funct3)
          3'b000:  ;                                   // FENCE, nothing to order here
          3'b001:  sys_op_o = SYS_FENCEI;
          default: match_o  = 1'b0;
        endcase
      end
      SYSTEM: begin
        if (funct3 != 3'b000 || instr_i[19:15] != 5'd0 || instr_i[11:7] != 5'd0) begin
          match_o = 1'b0;                              // CSR access or bad fields
        end else begin
          case (funct12)
            dec_isa_pkg::SYS_ECALL:  sys_op_o = dec_ctrl_pkg::SYS_ECALL;
            dec_isa_pkg::SYS_EBREAK: sys_op_o = dec_ctrl_pkg::SYS_EBREAK;
            dec_isa_pkg::SYS_MRET:   sys_op_o = dec_ctrl_pkg::SYS_MRET;
            dec_isa_pkg::SYS_WFI:    sys_op_o = dec_ctrl_pkg::SYS_WFI;
            default:                 match_o  = 1'b0;
          endcase
        end
      end
      default: match_o = 1'b0;                         // Unknown major opcode
    endcase
  end

endmodule

`default_nettype wire

//--- dec_id_stage.sv
/*
 Decode stage top. Credit flow control on both sides.
 An entry pops when queued and an execute credit is free. The decoded
 result is registered, so ex_valid_o and if_credit_o follow one cycle
 after the pop. Execute must not return more credits than it was sent.
*/
`timescale 1ns/100ps
`include "dec_settings.svh"
`default_nettype none

module dec_id_stage import dec_ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  // Fetch side
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  input  logic        instr_fault_i,
  output logic        if_credit_o,        // One pulse per popped entry
  // Execute side
  input  logic        ex_credit_i,
  output logic        ex_valid_o,
  output logic [31:0] ex_instr_o,
  output logic        ex_fault_o,
  output logic        ex_alu_en_o,
  output alu_op_e     ex_alu_op_o,
  output logic        ex_op_b_imm_o,
  output logic        ex_md_en_o,
  output md_op_e      ex_md_op_o,
  output logic        ex_rf_we_o,
  output logic [1:0]  ex_rf_re_o,
  output logic        ex_lsu_en_o,
  output logic        ex_lsu_we_o,
  output lsu_size_e   ex_lsu_size_o,
  output logic        ex_lsu_sign_ext_o,
  output branch_e     ex_branch_o,
  output sys_op_e     ex_sys_op_o,
  output logic        ex_illegal_o
);

  localparam int CRED_W = $clog2(`DEC_EX_CREDITS + 1);

  logic              q_empty, q_fault, pop;
  logic [31:0]       q_instr;
  logic [CRED_W-1:0] ex_credits;       // Free execute slots

  // Decoder outputs for the queue head
  logic       d_alu_en, d_op_b_imm, d_md_en, d_rf_we, d_lsu_en, d_lsu_we, d_sign_ext, d_illegal;
  logic [1:0] d_rf_re;
  alu_op_e    d_alu_op;
  md_op_e     d_md_op;
  lsu_size_e  d_lsu_size;
  branch_e    d_branch;
  sys_op_e    d_sys_op;

  assign pop = !q_empty && (ex_credits != '0);

  dec_instr_queue queue_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (instr_valid_i),
    .instr_i (instr_i),
    .fault_i (instr_fault_i),
    .pop_i   (pop),
    .empty_o (q_empty),
    .instr_o (q_instr),
    .fault_o (q_fault)
  );

  dec_decoder decoder_inst (
    .instr_i        (q_instr),
    .fault_i        (q_fault),
    .alu_en_o       (d_alu_en),
    .alu_op_o       (d_alu_op),
    .op_b_imm_o     (d_op_b_imm),
    .md_en_o        (d_md_en),
    .md_op_o        (d_md_op),
    .rf_we_o        (d_rf_we),
    .rf_re_o        (d_rf_re),
    .lsu_en_o       (d_lsu_en),
    .lsu_we_o       (d_lsu_we),
    .lsu_size_o     (d_lsu_size),
    .lsu_sign_ext_o (d_sign_ext),
    .branch_o       (d_branch),
    .sys_op_o       (d_sys_op),
    .illegal_o      (d_illegal)
  );

  //////////////////////////////////////////////////
  // Execute credits and valid/credit pulses
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_credits  <= CRED_W'(`DEC_EX_CREDITS);
      ex_valid_o  <= 1'b0;
      if_credit_o <= 1'b0;
    end else begin
      if (pop && !ex_credit_i)      ex_credits <= ex_credits - 1'b1;
      else if (!pop && ex_credit_i) ex_credits <= ex_credits + 1'b1;
      ex_valid_o  <= pop;
      if_credit_o <= pop;                    // Queue slot freed
    end
  end

  // Output payload, loaded on pop
  always_ff @(posedge clk_i) begin
    if (pop) begin
      ex_instr_o        <= q_instr;          // Execute pulls fields and immediates
      ex_fault_o        <= q_fault;
      ex_alu_en_o       <= d_alu_en;
      ex_alu_op_o       <= d_alu_op;
      ex_op_b_imm_o     <= d_op_b_imm;
      ex_md_en_o        <= d_md_en;
      ex_md_op_o        <= d_md_op;
      ex_rf_we_o        <= d_rf_we;
      ex_rf_re_o        <= d_rf_re;
      ex_lsu_en_o       <= d_lsu_en;
      ex_lsu_we_o       <= d_lsu_we;
      ex_lsu_size_o     <= d_lsu_size;
      ex_lsu_sign_ext_o <= d_sign_ext;
      ex_branch_o       <= d_branch;
      ex_sys_op_o       <= d_sys_op;
      ex_illegal_o      <= d_illegal;
    end
  end

  // Execute returned more credits than it received
  a_ex_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ex_credits <= CRED_W'(`DEC_EX_CREDITS));

endmodule

`default_nettype wire

//--- dec_instr_queue.sv
/*
 Circular FIFO of instruction words and fault flags.
 No full flag. Fetch credits keep pushes below DEC_QUEUE_DEPTH.
 Head entry is visible combinationally on instr_o / fault_o.
*/
`timescale 1ns/100ps
`include "dec_settings.svh"
`default_nettype none

module dec_instr_queue (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        push_i,
  input  logic [31:0] instr_i,
  input  logic        fault_i,
  input  logic        pop_i,
  output logic        empty_o,
  output logic [31:0] instr_o,
  output logic        fault_o
);

  localparam int DEPTH = `DEC_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  logic [31:0]      instr_mem [DEPTH];
  logic             fault_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [PTR_W:0]   count;            // Occupancy, 0..DEPTH

  // Storage, no reset
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      instr_mem[wr_ptr] <= instr_i;
      fault_mem[wr_ptr] <= fault_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop_i)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push_i && !pop_i)      count <= count + 1'b1;
      else if (pop_i && !push_i) count <= count - 1'b1;
    end
  end

  assign empty_o = (count == '0);
  assign instr_o = instr_mem[rd_ptr];
  assign fault_o = fault_mem[rd_ptr];

  // Fetch sent without a credit
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (count != (PTR_W+1)'(DEPTH)));

  // Stage popped with nothing queued
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- dec_isa_pkg.sv
/*
 RV32 instruction set encodings used by the decoders.
 Only the 32-bit (uncompressed) major opcodes are listed.
*/
`default_nettype none

package dec_isa_pkg;

  //////////////////////////////////////////////////
  // Major opcodes, instr[6:0]
  //////////////////////////////////////////////////
  typedef enum logic [6:0] {
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    OP_IMM   = 7'b0010011,
    OP       = 7'b0110011,
    MISC_MEM = 7'b0001111,   // FENCE, FENCE.I
    SYSTEM   = 7'b1110011
  } opcode_e;

  //////////////////////////////////////////////////
  // SYSTEM funct12, instr[31:20]
  //////////////////////////////////////////////////
  localparam logic [11:0] SYS_ECALL  = 12'h000;
  localparam logic [11:0] SYS_EBREAK = 12'h001;
  localparam logic [11:0] SYS_MRET   = 12'h302;
  localparam logic [11:0] SYS_WFI    = 12'h105;

  // funct7 of MUL/DIV/REM on the OP opcode
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

//--- dec_m_decoder.sv
/*
 RV32M decoder, purely combinational.
 Every funct3 value of the OP/MULDIV space is a valid instruction.
*/
`timescale 1ns/100ps
`default_nettype none

module dec_m_decoder import dec_isa_pkg::*; import dec_ctrl_pkg::*; (
  input  logic [31:0] instr_i,
  output logic        match_o,
  output md_op_e      md_op_o,
  output logic        rf_we_o,
  output logic [1:0]  rf_re_o
);

  assign match_o = (instr_i[6:0] == OP) && (instr_i[31:25] == FUNCT7_MULDIV);
  assign rf_we_o = match_o;
  assign rf_re_o = match_o ? 2'b11 : 2'b00;   // Both sources read

  // funct3 to operation
  always_comb begin
    case (instr_i[14:12])
      3'b000:  md_op_o = MUL;
      3'b001:  md_op_o = MULH;
      3'b010:  md_op_o = MULHSU;
      3'b011:  md_op_o = MULHU;
      3'b100:  md_op_o = DIV;
      3'b101:  md_op_o = DIVU;
      3'b110:  md_op_o = REM;
      default: md_op_o = REMU;
    endcase
  end

endmodule

`default_nettype wire

//--- dec_settings.svh
/*
 Build-time settings of the decode stage.
 DEC_QUEUE_DEPTH must be 2 or more. Fetch starts with that many credits.
 DEC_M_EXT set to 0 makes all RV32M encodings illegal.
*/
`ifndef DEC_SETTINGS_SVH
`define DEC_SETTINGS_SVH

// Instruction queue entries, also the fetch credits after reset
`define DEC_QUEUE_DEPTH 4

// Credits held toward execute after reset
`define DEC_EX_CREDITS 2

// 1 includes the multiply/divide decoder
`define DEC_M_EXT 1

`endif

//--- filelist.f
+incdir+.
dec_isa_pkg.sv
dec_ctrl_pkg.sv
dec_i_decoder.sv
dec_m_decoder.sv
dec_decoder.sv
dec_instr_queue.sv
dec_id_stage.sv
tb_dec_id_stage.sv

//--- tb_dec_id_stage.sv
/*
 Testbench for the decode stage. Rows of a stimulus table are sent under
 fetch credits and checked in order against each ex_valid_o pulse.
 Execute credits return after LFSR-driven gaps. M rows follow DEC_M_EXT.
*/
`timescale 1ns/100ps
`include "dec_settings.svh"
`default_nettype none

module tb_dec_id_stage import dec_ctrl_pkg::*; ();

  localparam int  MAX_ROWS = 32;
  localparam logic MX      = (`DEC_M_EXT != 0);   // M words decode, else illegal

  typedef struct {
    string       name;
    logic [31:0] instr;
    logic        fault;
    logic        illegal, alu_en, op_b_imm, md_en, rf_we, lsu_en, lsu_we, sign_ext;
    logic [1:0]  rf_re;
    alu_op_e     alu_op;
    md_op_e      md_op;
    lsu_size_e   lsu_size;
    branch_e     branch;
    sys_op_e     sys_op;
  } row_t;

  // DUT inputs
  logic        clk_i = 1'b0;
  logic        rst_n = 1'b0;
  logic        instr_valid = 1'b0;
  logic [31:0] instr = '0;
  logic        instr_fault = 1'b0;
  logic        ex_credit = 1'b0;

  // DUT outputs
  logic        if_credit_o, ex_valid_o, ex_fault_o, ex_alu_en_o, ex_op_b_imm_o, ex_md_en_o;
  logic        ex_rf_we_o, ex_lsu_en_o, ex_lsu_we_o, ex_lsu_sign_ext_o, ex_illegal_o;
  logic [31:0] ex_instr_o;
  logic [1:0]  ex_rf_re_o;
  alu_op_e     ex_alu_op_o;
  md_op_e      ex_md_op_o;
  lsu_size_e   ex_lsu_size_o;
  branch_e     ex_branch_o;
  sys_op_e     ex_sys_op_o;

  row_t        rows [MAX_ROWS];
  int          num_rows = 0;
  int          send_idx = 0, recv_idx = 0;     // Table positions, fetch and execute side
  int          if_credits = 0;                 // if_credit_o pulses seen
  int          ex_issued = 0, ex_returned = 0, ex_sent = 0;
  int          gap = 0;
  int          cycle_count = 0, limit = 0;
  int          pass_count = 0, fail_count = 0, other_errors = 0, row_errs = 0;
  logic        drain_error = 1'b0, timed_out = 1'b0;
  string       cur_name;
  logic [31:0] lfsr_state = 32'h6051;

  dec_id_stage dec_id_stage_inst (
    .clk_i (clk_i), .rst_n_i (rst_n),
    .instr_valid_i (instr_valid), .instr_i (instr), .instr_fault_i (instr_fault),
    .if_credit_o (if_credit_o), .ex_credit_i (ex_credit), .ex_valid_o (ex_valid_o),
    .ex_instr_o (ex_instr_o), .ex_fault_o (ex_fault_o), .ex_alu_en_o (ex_alu_en_o),
    .ex_alu_op_o (ex_alu_op_o), .ex_op_b_imm_o (ex_op_b_imm_o), .ex_md_en_o (ex_md_en_o),
    .ex_md_op_o (ex_md_op_o), .ex_rf_we_o (ex_rf_we_o), .ex_rf_re_o (ex_rf_re_o),
    .ex_lsu_en_o (ex_lsu_en_o), .ex_lsu_we_o (ex_lsu_we_o), .ex_lsu_size_o (ex_lsu_size_o),
    .ex_lsu_sign_ext_o (ex_lsu_sign_ext_o), .ex_branch_o (ex_branch_o),
    .ex_sys_op_o (ex_sys_op_o), .ex_illegal_o (ex_illegal_o)
  );

  initial begin
    forever #4 clk_i = ~clk_i;                  // 8 ns period
  end

  //////////////////////////////////////////////////
  // Instruction encoders, fixed rd=x1 rs1=x2 rs2=x3
  //////////////////////////////////////////////////
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [6:0] op);
    return {f7, 5'd3, 5'd2, f3, 5'd1, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [6:0] op);
    return {imm, 5'd2, f3, 5'd1, op};
  endfunction

  function automatic logic [31:0] enc_store(input logic [2:0] f3);
    return {7'h00, 5'd3, 5'd2, f3, 5'h04, dec_isa_pkg::STORE};
  endfunction

  function automatic logic [31:0] enc_sys(input logic [11:0] f12);
    return {f12, 5'd0, 3'b000, 5'd0, dec_isa_pkg::SYSTEM};
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  task automatic add_row(input string name, input logic [31:0] word, input logic flt,
                         input logic ill, input logic alu_en, input alu_op_e alu_op,
                         input logic imm, input logic md_en, input md_op_e md_op,
                         input logic we, input logic [1:0] re, input logic lsu_en,
                         input logic lsu_we, input lsu_size_e size, input logic sext,
                         input branch_e br, input sys_op_e sys);
    rows[num_rows] = '{name, word, flt, ill, alu_en, imm, md_en, we, lsu_en, lsu_we, sext,
                       re, alu_op, md_op, size, br, sys};
    num_rows++;
  endtask

  task automatic check_field(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: %s expected %0h actual %0h", cur_name, field, exp, act);
      row_errs++;
    end
  endtask

  // Compare the registered outputs with one table row
  task automatic check_row(input int idx);
    row_t r;
    r = rows[idx];
    cur_name = r.name;
    row_errs = 0;
    check_field("instr", r.instr, ex_instr_o);      // Also proves ordering
    check_field("fault", 32'(r.fault), 32'(ex_fault_o));
    check_field("illegal", 32'(r.illegal), 32'(ex_illegal_o));
    check_field("alu_en", 32'(r.alu_en), 32'(ex_alu_en_o));
    check_field("md_en", 32'(r.md_en), 32'(ex_md_en_o));
    check_field("rf_we", 32'(r.rf_we), 32'(ex_rf_we_o));
    check_field("lsu_en", 32'(r.lsu_en), 32'(ex_lsu_en_o));
    check_field("lsu_we", 32'(r.lsu_we), 32'(ex_lsu_we_o));
    check_field("branch", 32'(r.branch), 32'(ex_branch_o));
    check_field("sys_op", 32'(r.sys_op), 32'(ex_sys_op_o));
    // Register reads are not part of the fault suppression
    if (!r.fault) check_field("rf_re", 32'(r.rf_re), 32'(ex_rf_re_o));
    // Payload fields count only with their enable
    if (r.alu_en) begin
      check_field("alu_op", 32'(r.alu_op), 32'(ex_alu_op_o));
      check_field("op_b_imm", 32'(r.op_b_imm), 32'(ex_op_b_imm_o));
    end
    if (r.md_en) check_field("md_op", 32'(r.md_op), 32'(ex_md_op_o));
    if (r.lsu_en) check_field("lsu_size", 32'(r.lsu_size), 32'(ex_lsu_size_o));
    if (r.lsu_en && !r.lsu_we) check_field("sign_ext", 32'(r.sign_ext), 32'(ex_lsu_sign_ext_o));
    if (row_errs == 0) begin
      pass_count++;
      $display("PASS  %s", r.name);
    end else begin
      fail_count++;
      $display("FAIL  %s", r.name);
    end
  endtask

  //////////////////////////////////////////////////
  // Credit models and monitor
  //////////////////////////////////////////////////
  // Fetch side, sends while it holds a credit
  always @(posedge clk_i) begin
    if (rst_n && send_idx < num_rows && (send_idx - if_credits) < `DEC_QUEUE_DEPTH) begin
      instr_valid <= 1'b1;
      instr       <= rows[send_idx].instr;
      instr_fault <= rows[send_idx].fault;
      send_idx++;
    end else begin
      instr_valid <= 1'b0;
    end
  end

  // Execute side, one credit back per result after a random gap
  always @(posedge clk_i) begin
    cycle_count++;
    if (rst_n && ex_issued > ex_sent && gap == 0) begin
      ex_credit <= 1'b1;
      ex_sent++;
      gap = take_bits(3);                       // 0..7 idle cycles
    end else begin
      ex_credit <= 1'b0;
      if (gap > 0) gap--;
    end
  end

  // Sampled mid-cycle where registered outputs are settled
  always @(negedge clk_i) begin
    if (rst_n) begin
      if (if_credit_o) if_credits++;
      if (ex_valid_o) begin
        ex_issued++;
        if (ex_issued > ex_returned + `DEC_EX_CREDITS) begin
          $display("Execute credit overrun: %0d results issued against %0d credits returned",
                   ex_issued, ex_returned);
          other_errors++;
        end
        if (recv_idx >= num_rows) begin
          $display("ex_valid_o pulsed with no instruction left in the table");
          other_errors++;
        end else begin
          check_row(recv_idx);
          recv_idx++;
        end
      end
      // The stage only sees this credit at the next edge
      if (ex_credit) ex_returned++;
    end
  end

  //////////////////////////////////////////////////
  // Table and run control
  //////////////////////////////////////////////////
  initial begin
    //        name        word                                     flt ill alu op   imm
    //        md op   we re lsu we size sext branch sys
    add_row("ADD", enc_r(7'h00, 3'b000, dec_isa_pkg::OP), 0, 0, 1, ADD, 0,
            0, MUL, 1, 2'b11, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("SUB", enc_r(7'h20, 3'b000, dec_isa_pkg::OP), 0, 0, 1, SUB, 0,
            0, MUL, 1, 2'b11, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("SRA", enc_r(7'h20, 3'b101, dec_isa_pkg::OP), 0, 0, 1, SRA, 0,
            0, MUL, 1, 2'b11, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("SLTIU", enc_i(12'h005, 3'b011, dec_isa_pkg::OP_IMM), 0, 0, 1, SLTU, 1,
            0, MUL, 1, 2'b01, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("LUI", {20'h12345, 5'd1, dec_isa_pkg::LUI}, 0, 0, 1, PASS_B, 1,
            0, MUL, 1, 2'b00, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("LW", enc_i(12'h010, 3'b010, dec_isa_pkg::LOAD), 0, 0, 0, ADD, 0,
            0, MUL, 1, 2'b01, 1, 0, LSU_WORD, 1, BR_NONE, SYS_NONE);
    add_row("LBU", enc_i(12'h011, 3'b100, dec_isa_pkg::LOAD), 0, 0, 0, ADD, 0,
            0, MUL, 1, 2'b01, 1, 0, LSU_BYTE, 0, BR_NONE, SYS_NONE);
    add_row("LH", enc_i(12'h012, 3'b001, dec_isa_pkg::LOAD), 0, 0, 0, ADD, 0,
            0, MUL, 1, 2'b01, 1, 0, LSU_HALF, 1, BR_NONE, SYS_NONE);
    add_row("SW", enc_store(3'b010), 0, 0, 0, ADD, 0,
            0, MUL, 0, 2'b11, 1, 1, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("SB", enc_store(3'b000), 0, 0, 0, ADD, 0,
            0, MUL, 0, 2'b11, 1, 1, LSU_BYTE, 0, BR_NONE, SYS_NONE);
    add_row("JAL", {20'h00100, 5'd1, dec_isa_pkg::JAL}, 0, 0, 1, ADD, 1,
            0, MUL, 1, 2'b00, 0, 0, LSU_WORD, 0, BR_JAL, SYS_NONE);
    add_row("JALR", enc_i(12'h004, 3'b000, dec_isa_pkg::JALR), 0, 0, 1, ADD, 1,
            0, MUL, 1, 2'b01, 0, 0, LSU_WORD, 0, BR_JALR, SYS_NONE);
    add_row("BEQ", {7'h00, 5'd3, 5'd2, 3'b000, 5'h08, dec_isa_pkg::BRANCH}, 0, 0, 1, SUB, 0,
            0, MUL, 0, 2'b11, 0, 0, LSU_WORD, 0, BR_COND, SYS_NONE);
    add_row("MUL", enc_r(7'h01, 3'b000, dec_isa_pkg::OP), 0, !MX, 0, ADD, 0,
            MX, MUL, MX, {MX, MX}, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("MULHU", enc_r(7'h01, 3'b011, dec_isa_pkg::OP), 0, !MX, 0, ADD, 0,
            MX, MULHU, MX, {MX, MX}, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("DIV", enc_r(7'h01, 3'b100, dec_isa_pkg::OP), 0, !MX, 0, ADD, 0,
            MX, DIV, MX, {MX, MX}, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("REMU", enc_r(7'h01, 3'b111, dec_isa_pkg::OP), 0, !MX, 0, ADD, 0,
            MX, REMU, MX, {MX, MX}, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("ECALL", enc_sys(dec_isa_pkg::SYS_ECALL), 0, 0, 0, ADD, 0,
            0, MUL, 0, 2'b00, 0, 0, LSU_WORD, 0, BR_NONE, SYS_ECALL);
    add_row("EBREAK", enc_sys(dec_isa_pkg::SYS_EBREAK), 0, 0, 0, ADD, 0,
            0, MUL, 0, 2'b00, 0, 0, LSU_WORD, 0, BR_NONE, SYS_EBREAK);
    add_row("MRET", enc_sys(dec_isa_pkg::SYS_MRET), 0, 0, 0, ADD, 0,
            0, MUL, 0, 2'b00, 0, 0, LSU_WORD, 0, BR_NONE, SYS_MRET);
    add_row("WFI", enc_sys(dec_isa_pkg::SYS_WFI), 0, 0, 0, ADD, 0,
            0, MUL, 0, 2'b00, 0, 0, LSU_WORD, 0, BR_NONE, SYS_WFI);
    add_row("FENCE_I", {12'h000, 5'd0, 3'b001, 5'd0, dec_isa_pkg::MISC_MEM}, 0, 0, 0, ADD, 0,
            0, MUL, 0, 2'b00, 0, 0, LSU_WORD, 0, BR_NONE, SYS_FENCEI);
    add_row("BAD_OPCODE", 32'h0000_007F, 0, 1, 0, ADD, 0,
            0, MUL, 0, 2'b00, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("BAD_FUNCT7", enc_r(7'h10, 3'b000, dec_isa_pkg::OP), 0, 1, 0, ADD, 0,
            0, MUL, 0, 2'b00, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    // Fetch faults, everything inactive
    add_row("FAULT_ADD", enc_r(7'h00, 3'b000, dec_isa_pkg::OP), 1, 0, 0, ADD, 0,
            0, MUL, 0, 2'b11, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("FAULT_BAD", 32'h0000_007F, 1, 0, 0, ADD, 0,
            0, MUL, 0, 2'b00, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("FAULT_JAL", {20'h00100, 5'd1, dec_isa_pkg::JAL}, 1, 0, 0, ADD, 0,
            0, MUL, 0, 2'b00, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    add_row("FAULT_ECALL", enc_sys(dec_isa_pkg::SYS_ECALL), 1, 0, 0, ADD, 0,
            0, MUL, 0, 2'b00, 0, 0, LSU_WORD, 0, BR_NONE, SYS_NONE);
    limit = 40 * num_rows + 100;

    repeat (4) @(posedge clk_i);
    rst_n <= 1'b1;

    // Drained once every result and every fetch credit is back
    while (!(recv_idx >= num_rows && if_credits >= num_rows) && cycle_count < limit)
      @(negedge clk_i);
    if (cycle_count >= limit) begin
      timed_out = 1'b1;
      $display("Run timed out after %0d cycles with %0d of %0d results seen",
               cycle_count, recv_idx, num_rows);
    end else if (if_credits != send_idx) begin
      drain_error = 1'b1;
      $display("Fetch got %0d credits back for %0d instructions sent", if_credits, send_idx);
    end

    $display("Tests: %0d passed, %0d failed, %0d other errors", pass_count, fail_count,
             other_errors + int'(drain_error));
    if (fail_count == 0 && other_errors == 0 && !drain_error && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
